/* all.f */
design/io_map_pkg.sv
design/ctrl_pkg.sv
design/bus_front.sv
design/config_regs.sv
design/int_ctrl.sv
design/gate_array_top.sv
test/gate_array_assert.sv
test/gate_array_checker.sv
test/tb_gate_array.sv

/* Bender.yml */
package:
  name: gate_array

sources:
  - files:
      - design/io_map_pkg.sv
      - design/ctrl_pkg.sv
      - design/bus_front.sv
      - design/config_regs.sv
      - design/int_ctrl.sv
      - design/gate_array_top.sv
  - target: test
    files:
      - test/gate_array_assert.sv
      - test/gate_array_checker.sv
      - test/tb_gate_array.sv

/* test/tb_gate_array.sv */
// Gate array testbench: clock, reset, bus stimulus, random source and watchdog
`timescale 1ns/1ns
`default_nettype none

module tb_gate_array;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 10;
    // Rough cycles per test: reset, paging, video, timer, disk NMI, back-pressure
    localparam int TEST_CYCLES     = RESET_CYCLES + 20 + 60 + 100 + 240 + 80 + 40;
    localparam int WATCHDOG_CYCLES = 2 * TEST_CYCLES + 200;    // Twice the estimate plus slack

    logic                               clk_sys;
    logic                               reset;
    logic                               req_valid;
    io_map_pkg::io_req_t                req;
    logic                               req_ready;
    logic                               rsp_valid;
    logic                               rsp_ready;
    io_map_pkg::io_rsp_t                rsp;
    logic [15:0]                        cpu_addr;
    logic [ctrl_pkg::RAM_ADDR_BITS-1:0] ram_addr;
    ctrl_pkg::video_ctrl_t              video_ctrl;
    ctrl_pkg::sys_ctrl_t                sys_ctrl;
    logic                               timer_tick;
    logic                               fdc_int;
    logic                               iff1;
    logic                               vblank;
    logic                               ntsc;
    logic                               int_req;
    logic                               nmi_req;
    logic [31:0]                        lcg_state;     // Random generator state

    gate_array_top UUT (
        .clk_sys, .reset, .req_valid, .req, .req_ready, .rsp_valid, .rsp_ready, .rsp,
        .cpu_addr, .ram_addr, .video_ctrl, .sys_ctrl, .timer_tick, .fdc_int, .iff1,
        .vblank, .ntsc, .int_req, .nmi_req
    );

    gate_array_checker u_checker (
        .clk_sys, .reset, .req_valid, .req, .req_ready, .rsp_valid, .rsp_ready, .rsp,
        .cpu_addr, .ram_addr, .video_ctrl, .sys_ctrl, .vblank, .ntsc
    );

    initial
    begin
        clk_sys = 1'b0;
        forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
    end

    // Linear congruential step
    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic draw(output logic [15:0] value);
        lcg_state = lcg_next(lcg_state);
        value     = lcg_state[31:16];          // Upper half has the longer period
    endtask

    // One request, held until the handshake completes
    task automatic send(input logic wr, input logic [7:0] port, input logic [7:0] data);
        @(posedge clk_sys);
        req_valid <= 1'b1;
        req       <= {wr, port, data};
        @(negedge clk_sys);
        while (!req_ready)
            @(negedge clk_sys);
        @(posedge clk_sys);                    // Acceptance edge
        req_valid <= 1'b0;
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk_sys);
    endtask

    // Single high cycle, then a gap of five low cycles
    task automatic pulse_tick();
        @(posedge clk_sys);
        timer_tick <= 1'b1;
        @(posedge clk_sys);
        timer_tick <= 1'b0;
        wait_cycles(5);
    endtask

    // Until every accepted request has been answered
    task automatic drain();
        @(negedge clk_sys);
        while (u_checker.pending != 0)
            @(negedge clk_sys);
    endtask

    initial
    begin
        logic [15:0] rnd;
        logic [7:0]  held;
        logic [3:0]  code;

        reset      = 1'b1;
        req_valid  = 1'b0;
        req        = '0;
        rsp_ready  = 1'b1;
        cpu_addr   = 16'h0000;
        timer_tick = 1'b0;
        fdc_int    = 1'b0;
        iff1       = 1'b0;
        vblank     = 1'b0;
        ntsc       = 1'b0;
        lcg_state  = 32'h7164;
        wait_cycles(RESET_CYCLES);
        reset <= 1'b0;

        u_checker.start_test("reset state");
        @(negedge clk_sys);
        u_checker.check_value("video_ctrl.inverse", video_ctrl.inverse, 1);
        u_checker.check_value("video_ctrl.disable_vid", video_ctrl.disable_vid, 1);
        u_checker.check_value("sys_ctrl", sys_ctrl, 0);
        u_checker.check_value("rsp_valid", rsp_valid, 0);
        u_checker.check_value("int_req", int_req, 0);
        u_checker.check_value("nmi_req", nmi_req, 0);
        u_checker.finish_test();

        // ram_addr is compared by the checker on every cycle
        u_checker.start_test("paging");
        for (int i = 0; i < 4; i++)
        begin
            draw(rnd);
            send(1'b1, 8'(io_map_pkg::PORT_PAGE0 + i), rnd[7:0]);   // High nibble ignored
        end
        for (int i = 0; i < 20; i++)
        begin
            draw(rnd);
            @(posedge clk_sys);
            cpu_addr <= rnd;
        end
        drain();
        u_checker.finish_test();

        u_checker.start_test("video and commands");
        draw(rnd);
        send(1'b1, io_map_pkg::PORT_ROLLER, rnd[7:0]);
        draw(rnd);
        send(1'b1, io_map_pkg::PORT_YSCROLL, rnd[7:0]);
        draw(rnd);
        send(1'b1, io_map_pkg::PORT_VIDMODE, rnd[7:0]);
        // Every code in order, then random codes on top of a mixed state
        for (int i = 0; i < 32; i++)
        begin
            draw(rnd);
            code = (i < 16) ? 4'(i) : rnd[11:8];
            send(1'b1, io_map_pkg::PORT_STATUS, {rnd[7:4], code});
        end
        drain();
        u_checker.finish_test();

        u_checker.start_test("timer");
        draw(rnd);
        @(posedge clk_sys);
        iff1   <= 1'b1;
        vblank <= rnd[0];
        ntsc   <= rnd[1];
        repeat (18) pulse_tick();
        @(negedge clk_sys);
        u_checker.check_value("int_req", int_req, 1);
        u_checker.expect_int_state(1'b0, 4'd15);        // Saturated after 18 ticks
        send(1'b0, io_map_pkg::PORT_STATUS, 8'h00);
        send(1'b0, io_map_pkg::PORT_TIMER_ACK, 8'h00);  // Starts the delayed clear
        drain();
        wait_cycles(40);
        u_checker.expect_int_state(1'b0, 4'd0);
        send(1'b0, io_map_pkg::PORT_STATUS, 8'h00);
        drain();
        u_checker.check_value("int_req", int_req, 0);
        u_checker.finish_test();

        u_checker.start_test("disk nmi");
        draw(rnd);
        send(1'b1, io_map_pkg::PORT_STATUS, {rnd[7:4], io_map_pkg::CMD_DISK_NMI});
        @(posedge clk_sys);
        fdc_int <= 1'b1;
        wait_cycles(4);
        pulse_tick();
        @(negedge clk_sys);
        u_checker.check_value("nmi_req", nmi_req, 1);
        u_checker.expect_int_state(1'b1, 4'd1);         // One tick since the clear
        send(1'b0, io_map_pkg::PORT_STATUS, 8'h00);
        drain();
        send(1'b1, io_map_pkg::PORT_STATUS, {rnd[15:12], io_map_pkg::CMD_DISK_OFF});
        pulse_tick();
        @(negedge clk_sys);
        u_checker.check_value("nmi_req", nmi_req, 0);
        @(posedge clk_sys);
        fdc_int <= 1'b0;
        wait_cycles(4);                                 // Let the falling edge clear the latch
        u_checker.finish_test();

        u_checker.start_test("back-pressure");
        u_checker.expect_int_state(1'b0, 4'd2);
        @(posedge clk_sys);
        rsp_ready <= 1'b0;
        send(1'b0, io_map_pkg::PORT_STATUS, 8'h00);
        fork
            send(1'b0, 8'h3C, 8'h00);                   // Unmapped port, waits behind the first
            begin
                @(negedge clk_sys);
                held = rsp.data;
                repeat (6)
                begin
                    u_checker.check_value("req_ready", req_ready, 0);
                    u_checker.check_value("rsp_valid", rsp_valid, 1);
                    u_checker.check_value("rsp", rsp.data, held);
                    @(negedge clk_sys);
                end
                @(posedge clk_sys);
                rsp_ready <= 1'b1;
            end
        join
        drain();
        u_checker.finish_test();

        u_checker.report_counts();
        if (u_checker.error_count == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

    initial
    begin
        wait_cycles(WATCHDOG_CYCLES);
        $display("Watchdog expired: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* test/gate_array_checker.sv */
// Gate array scoreboard: reference model of registers and status, response queue and counts
`timescale 1ns/1ns
`default_nettype none

module gate_array_checker (
    input wire                               clk_sys,
    input wire                               reset,
    input wire                               req_valid,
    input wire io_map_pkg::io_req_t          req,
    input wire                               req_ready,
    input wire                               rsp_valid,
    input wire                               rsp_ready,
    input wire io_map_pkg::io_rsp_t          rsp,
    input wire [15:0]                        cpu_addr,
    input wire [ctrl_pkg::RAM_ADDR_BITS-1:0] ram_addr,
    input wire ctrl_pkg::video_ctrl_t        video_ctrl,
    input wire ctrl_pkg::sys_ctrl_t          sys_ctrl,
    input wire                               vblank,
    input wire                               ntsc
);

    int    error_count = 0;
    int    check_count = 0;
    int    test_errors = 0;
    int    pending = 0;         // Responses still owed
    string test_name = "";

    logic [3:0]            page_model [4];
    ctrl_pkg::video_ctrl_t video_model;
    ctrl_pkg::sys_ctrl_t   sys_model;
    logic                  exp_fdc_latch = 1'b0;    // Interrupt state the next status reads expect
    logic [3:0]            exp_misses = 4'd0;
    logic [7:0]            rsp_queue [$];

    // 0, vblank, fdc latch, inverted ntsc, four miss bits
    function automatic logic [7:0] status_byte(input logic vb, input logic nt,
                                               input logic fdc, input logic [3:0] misses);
        return {1'b0, vb, fdc, ~nt, misses};
    endfunction

    function automatic logic [17:0] translate_addr(input logic [3:0] page,
                                                   input logic [15:0] addr);
        return {page, addr[13:0]};  // Page bits over the 16 KB offset
    endfunction

    // Effect of one command nibble on the system control bits
    function automatic ctrl_pkg::sys_ctrl_t decode_command(input ctrl_pkg::sys_ctrl_t cur,
                                                           input logic [3:0] code);
        ctrl_pkg::sys_ctrl_t nxt;
        nxt = cur;
        case (code)
            4'd2:
            begin
                nxt.disk_to_nmi = 1'b1;
                nxt.disk_to_int = 1'b0;
            end
            4'd3:
            begin
                nxt.disk_to_nmi = 1'b0;
                nxt.disk_to_int = 1'b1;
            end
            4'd4:
            begin
                nxt.disk_to_nmi = 1'b0;
                nxt.disk_to_int = 1'b0;
            end
            4'd5:  nxt.tc = 1'b1;
            4'd6:  nxt.tc = 1'b0;
            4'd9:  nxt.motor = 1'b1;
            4'd10: nxt.motor = 1'b0;
            4'd11: nxt.speaker_enable = 1'b1;
            4'd12: nxt.speaker_enable = 1'b0;
            default: ;                      // No effect
        endcase
        return nxt;
    endfunction

    task automatic apply_write(input logic [7:0] port, input logic [7:0] data);
        case (port)
            8'hF0, 8'hF1, 8'hF2, 8'hF3: page_model[port[1:0]] = data[3:0];
            8'hF5: video_model.roller_ptr = data;
            8'hF6: video_model.yscroll    = data;
            8'hF7:
            begin
                video_model.inverse     = data[7];
                video_model.disable_vid = ~data[6];     // Bit 6 enables video
            end
            8'hF8: sys_model = decode_command(sys_model, data[3:0]);
            default: ;
        endcase
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        check_count++;
        if (actual !== expected)
        begin
            error_count++;
            test_errors++;
            $display("[FAIL] %0t ns %s expected %0h got %0h", $time, name, expected, actual);
        end
    endtask

    task automatic expect_int_state(input logic fdc, input logic [3:0] misses);
        exp_fdc_latch = fdc;
        exp_misses    = misses;
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic finish_test();
        if (test_errors == 0)
            $display("Test %s: ok", test_name);
        else
            $display("Test %s: %0d errors", test_name, test_errors);
    endtask

    task automatic report_counts();
        if (pending != 0)
        begin
            error_count++;
            $display("%0d accepted requests never got a response", pending);
        end
        $display("Checks: %0d, errors: %0d", check_count, error_count);
    endtask

    // Mid-cycle sampling, everything driven on the rising edge is settled here
    always @(negedge clk_sys)
    begin
        if (reset)
        begin
            for (int i = 0; i < 4; i++)
                page_model[i] = 4'h0;
            video_model = {8'h00, 8'h00, 1'b1, 1'b1};   // F7 at 80, inverse and disable high
            sys_model   = '0;
            rsp_queue.delete();
        end
        else
        begin
            // Writes accepted this cycle are not visible yet
            check_value("ram_addr", ram_addr, translate_addr(page_model[cpu_addr[15:14]], cpu_addr));
            check_value("video_ctrl", video_ctrl, video_model);
            check_value("sys_ctrl", sys_ctrl, sys_model);
            if (rsp_valid && rsp_ready)
            begin
                if (rsp_queue.size() == 0)
                begin
                    error_count++;
                    test_errors++;
                    $display("Response at %0t ns without an outstanding request", $time);
                end
                else
                    check_value("rsp", rsp.data, rsp_queue.pop_front());
            end
            if (req_valid && req_ready)
            begin
                if (req.wr)
                begin
                    apply_write(req.port, req.data);
                    rsp_queue.push_back(8'hFF);
                end
                else if (req.port == 8'hF8 || req.port == 8'hF4)
                    rsp_queue.push_back(status_byte(vblank, ntsc, exp_fdc_latch, exp_misses));
                else
                    rsp_queue.push_back(8'hFF);     // Unmapped read
            end
        end
        pending = rsp_queue.size();
    end

endmodule

`default_nettype wire

/* test/gate_array_assert.sv */
// Handshake and reset assertions for the bus front end
`timescale 1ns/1ns
`default_nettype none

module gate_array_assert (
    input wire                      clk_sys,
    input wire                      reset,
    input wire                      req_valid,
    input wire io_map_pkg::io_req_t req,
    input wire                      req_ready,
    input wire                      rsp_valid,
    input wire                      rsp_ready,
    input wire io_map_pkg::io_rsp_t rsp
);

    // Stalled request stays put until accepted
    req_stable: assert property (@(posedge clk_sys) disable iff (reset)
        (req_valid && !req_ready) |=> (req_valid && $stable(req)))
        else $error("Request changed or dropped while stalled");

    rsp_stable: assert property (@(posedge clk_sys) disable iff (reset)
        (rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp)))
        else $error("Held response changed before it was taken");

    // Every acceptance fills the response slot on the next edge
    rsp_follows: assert property (@(posedge clk_sys) disable iff (reset)
        (req_valid && req_ready) |=> rsp_valid)
        else $error("No response in the cycle after an accepted request");

    reset_idle: assert property (@(posedge clk_sys) reset |=> !rsp_valid)
        else $error("rsp_valid high after reset");   // Response slot empty

endmodule

bind bus_front gate_array_assert u_handshake_assert (.*);

`default_nettype wire

/* design/gate_array_top.sv */
// Gate array system control top: bus front end, configuration registers and interrupts
`timescale 1ns/1ns
`default_nettype none

module gate_array_top (
    input  wire                      clk_sys,
    input  wire                      reset,
    input  wire                      req_valid,
    input  wire io_map_pkg::io_req_t req,
    output logic                     req_ready,
    output logic                     rsp_valid,
    input  wire                      rsp_ready,
    output io_map_pkg::io_rsp_t      rsp,
    input  wire [15:0]               cpu_addr,
    output logic [ctrl_pkg::RAM_ADDR_BITS-1:0] ram_addr,
    output ctrl_pkg::video_ctrl_t    video_ctrl,
    output ctrl_pkg::sys_ctrl_t      sys_ctrl,
    input  wire                      timer_tick,
    input  wire                      fdc_int,
    input  wire                      iff1,
    input  wire                      vblank,
    input  wire                      ntsc,
    output logic                     int_req,
    output logic                     nmi_req
);

    logic                  wr_valid;
    io_map_pkg::io_req_t   wr_req;
    logic                  timer_ack;
    logic                  mode_change;
    ctrl_pkg::int_status_t int_status;

    bus_front u_bus_front (
        .clk_sys, .reset, .req_valid, .req, .req_ready, .rsp_valid, .rsp_ready, .rsp,
        .int_status, .vblank, .ntsc, .wr_valid, .wr_req, .timer_ack
    );

    config_regs u_config_regs (
        .clk_sys, .reset, .wr_valid, .wr_req, .cpu_addr,
        .ram_addr, .video_ctrl, .sys_ctrl, .mode_change
    );

    int_ctrl u_int_ctrl (
        .clk_sys, .reset, .timer_tick, .fdc_int, .iff1, .sys_ctrl, .mode_change,
        .timer_ack, .int_status, .int_req, .nmi_req
    );

endmodule

`default_nettype wire

/* design/int_ctrl.sv */
// Interrupt control: 300 Hz timer with miss count, floppy latch, NMI flag and INT lines
`timescale 1ns/1ns
`default_nettype none

module int_ctrl (
    input  wire                      clk_sys,
    input  wire                      reset,
    input  wire                      timer_tick,    // 300 Hz from video timing
    input  wire                      fdc_int,       // Floppy controller interrupt
    input  wire                      iff1,          // CPU interrupt enable
    input  wire ctrl_pkg::sys_ctrl_t sys_ctrl,
    input  wire                      mode_change,
    input  wire                      timer_ack,     // Port F4 read accepted
    output ctrl_pkg::int_status_t    int_status,
    output logic                     int_req,
    output logic                     nmi_req
);

    // Input sampling and edge detect
    logic timer_q, timer_d;
    logic fdc_q, fdc_d;
    logic timer_rise;
    logic fdc_rise, fdc_fall;

    logic nmi_flag;         // Pending disk NMI, released on the next tick
    logic timer_line;
    logic int_line;         // Disk interrupt on INT
    logic nmi_line;
    logic clear_active;     // Timer clear countdown running
    logic [$clog2(ctrl_pkg::TIMER_CLEAR_CYCLES)-1:0] clear_count;

    assign timer_rise = timer_q & ~timer_d;
    assign fdc_rise   = fdc_q & ~fdc_d;
    assign fdc_fall   = ~fdc_q & fdc_d;

    always_ff @(posedge clk_sys)
    begin
        timer_q <= timer_tick;
        timer_d <= timer_q;
        fdc_q   <= fdc_int;
        fdc_d   <= fdc_q;
    end

    always_ff @(posedge clk_sys)
    begin
        if (reset)
        begin
            int_status   <= '0;
            nmi_flag     <= 1'b0;
            timer_line   <= 1'b0;
            int_line     <= 1'b0;
            nmi_line     <= 1'b0;
            clear_active <= 1'b0;
            clear_count  <= '0;
        end
        else
        begin
            if (timer_rise)
            begin
                if (~&int_status.miss_count)
                    int_status.miss_count <= int_status.miss_count + 1'b1;  // Saturates
                timer_line <= iff1;
                nmi_line   <= nmi_flag;             // NMI only fires on a tick
                int_line   <= sys_ctrl.disk_to_int & int_status.fdc_latch & iff1;
            end

            if (fdc_rise)
            begin
                int_status.fdc_latch <= 1'b1;
                if (sys_ctrl.disk_to_nmi)
                    nmi_flag <= 1'b1;
            end
            else if (fdc_fall)
                int_status.fdc_latch <= 1'b0;

            // Delayed clear after status acknowledge, a new ack restarts it
            if (timer_ack)
            begin
                clear_active <= 1'b1;
                clear_count  <= '0;
            end
            else if (clear_active)
            begin
                if (clear_count == $bits(clear_count)'(ctrl_pkg::TIMER_CLEAR_CYCLES - 1))
                begin
                    clear_active          <= 1'b0;
                    timer_line            <= 1'b0;   // Wins over a tick in the same cycle
                    int_status.miss_count <= '0;
                end
                else
                    clear_count <= clear_count + 1'b1;
            end

            // Routing change drops whatever the new mode no longer uses
            if (mode_change)
            begin
                if (sys_ctrl.disk_to_nmi)
                    int_line <= 1'b0;
                else if (sys_ctrl.disk_to_int)
                    nmi_flag <= 1'b0;
                else
                begin
                    int_line <= 1'b0;
                    nmi_flag <= 1'b0;
                end
            end
        end
    end

    assign int_req = int_line | timer_line;    // Disk and timer share INT
    assign nmi_req = nmi_line;

endmodule

`default_nettype wire

/* design/config_regs.sv */
// Paging and video registers, system command decoder and CPU to RAM address mapping
`timescale 1ns/1ns
`default_nettype none

module config_regs (
    input  wire                      clk_sys,
    input  wire                      reset,
    input  wire                      wr_valid,      // Accepted write this cycle
    input  wire io_map_pkg::io_req_t wr_req,
    input  wire [15:0]               cpu_addr,
    output logic [ctrl_pkg::RAM_ADDR_BITS-1:0] ram_addr,
    output ctrl_pkg::video_ctrl_t    video_ctrl,
    output ctrl_pkg::sys_ctrl_t      sys_ctrl,
    output logic                     mode_change    // Disk routing changed last cycle
);

    logic [ctrl_pkg::PAGE_BITS-1:0] page_reg [4];   // One per 16 KB window
    logic [3:0]                     cmd;
    logic [1:0]                     window;

    assign cmd    = wr_req.data[3:0];
    assign window = cpu_addr[15:ctrl_pkg::OFFSET_BITS];    // Top two CPU address bits

    // Page number from the selected window, offset passes straight through
    assign ram_addr = {page_reg[window], cpu_addr[ctrl_pkg::OFFSET_BITS-1:0]};

    always_ff @(posedge clk_sys)
    begin
        if (reset)
        begin
            for (int i = 0; i < 4; i++)
                page_reg[i] <= '0;
            video_ctrl.roller_ptr  <= 8'h00;
            video_ctrl.yscroll     <= 8'h00;
            video_ctrl.inverse     <= ctrl_pkg::VIDMODE_RESET[7];
            video_ctrl.disable_vid <= ~ctrl_pkg::VIDMODE_RESET[6];  // Bit 6 is an enable
            sys_ctrl    <= '0;
            mode_change <= 1'b0;
        end
        else
        begin
            mode_change <= 1'b0;
            if (wr_valid)
            begin
                case (wr_req.port)
                    // F0 to F3, low port bits pick the window
                    io_map_pkg::PORT_PAGE0, io_map_pkg::PORT_PAGE1,
                    io_map_pkg::PORT_PAGE2, io_map_pkg::PORT_PAGE3:
                        page_reg[wr_req.port[1:0]] <= wr_req.data[ctrl_pkg::PAGE_BITS-1:0];
                    io_map_pkg::PORT_ROLLER:  video_ctrl.roller_ptr <= wr_req.data;
                    io_map_pkg::PORT_YSCROLL: video_ctrl.yscroll    <= wr_req.data;
                    io_map_pkg::PORT_VIDMODE:
                    begin
                        video_ctrl.inverse     <= wr_req.data[7];
                        video_ctrl.disable_vid <= ~wr_req.data[6];
                    end
                    io_map_pkg::PORT_STATUS:
                    begin
                        // System command nibble
                        case (cmd)
                            io_map_pkg::CMD_DISK_NMI:
                            begin
                                sys_ctrl.disk_to_nmi <= 1'b1;
                                sys_ctrl.disk_to_int <= 1'b0;   // No mode_change here
                            end
                            io_map_pkg::CMD_DISK_INT:
                            begin
                                sys_ctrl.disk_to_nmi <= 1'b0;
                                sys_ctrl.disk_to_int <= 1'b1;
                                mode_change          <= 1'b1;
                            end
                            io_map_pkg::CMD_DISK_OFF:
                            begin
                                sys_ctrl.disk_to_nmi <= 1'b0;
                                sys_ctrl.disk_to_int <= 1'b0;
                                mode_change          <= 1'b1;
                            end
                            io_map_pkg::CMD_TC_SET:    sys_ctrl.tc             <= 1'b1;
                            io_map_pkg::CMD_TC_CLR:    sys_ctrl.tc             <= 1'b0;
                            io_map_pkg::CMD_MOTOR_ON:  sys_ctrl.motor          <= 1'b1;
                            io_map_pkg::CMD_MOTOR_OFF: sys_ctrl.motor          <= 1'b0;
                            io_map_pkg::CMD_SPK_ON:    sys_ctrl.speaker_enable <= 1'b1;
                            io_map_pkg::CMD_SPK_OFF:   sys_ctrl.speaker_enable <= 1'b0;
                            default: ;  // Bootstrap end, reset and spare codes ignored
                        endcase
                    end
                    default: ;          // Other ports belong elsewhere
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* design/bus_front.sv */
// I/O request front end: handshake, held response and status byte assembly
`timescale 1ns/1ns
`default_nettype none

module bus_front (
    input  wire                    clk_sys,
    input  wire                    reset,
    // Request channel
    input  wire                    req_valid,
    input  wire io_map_pkg::io_req_t req,
    output logic                   req_ready,
    // Response channel
    output logic                   rsp_valid,
    input  wire                    rsp_ready,
    output io_map_pkg::io_rsp_t    rsp,
    // Status sources
    input  wire ctrl_pkg::int_status_t int_status,
    input  wire                    vblank,
    input  wire                    ntsc,
    // Strobes into the register and interrupt blocks
    output logic                   wr_valid,
    output io_map_pkg::io_req_t    wr_req,
    output logic                   timer_ack
);

    logic       accept;         // Handshake completes this cycle
    logic       status_read;    // IN from F8 or F4
    logic [7:0] status_byte;

    assign req_ready = ~rsp_valid | rsp_ready;     // Free slot, or the held one drains now
    assign accept    = req_valid & req_ready;

    assign status_read = ~req.wr &
                         ((req.port == io_map_pkg::PORT_STATUS) |
                          (req.port == io_map_pkg::PORT_TIMER_ACK));

    // Bit 7 always reads 0, ntsc is reported inverted
    assign status_byte = {1'b0, vblank, int_status.fdc_latch, ~ntsc, int_status.miss_count};

    // Strobes only fire in the acceptance cycle
    assign wr_valid  = accept & req.wr;
    assign wr_req    = req;
    assign timer_ack = accept & ~req.wr & (req.port == io_map_pkg::PORT_TIMER_ACK);

    // Response valid flag
    always_ff @(posedge clk_sys)
    begin
        if (reset)
            rsp_valid <= 1'b0;
        else if (accept)
            rsp_valid <= 1'b1;          // New response replaces a drained one
        else if (rsp_ready)
            rsp_valid <= 1'b0;
    end

    // Response payload, held until the next acceptance
    always_ff @(posedge clk_sys)
    begin
        if (accept)
            rsp.data <= status_read ? status_byte : io_map_pkg::IDLE_READ_DATA;
    end

endmodule

`default_nettype wire

/* design/ctrl_pkg.sv */
// Control and status types for the gate array, with address and timer constants
`default_nettype none

package ctrl_pkg;

    // Address translation widths
    localparam int PAGE_BITS     = 4;    // 16 pages of 16 KB
    localparam int OFFSET_BITS   = 14;   // Offset inside a window
    localparam int RAM_ADDR_BITS = 18;   // 256 KB of RAM

    // Missed 300 Hz ticks, saturates at all ones
    localparam int MISS_BITS = 4;

    // Cycles from a port F4 read until the timer state is cleared
    localparam int TIMER_CLEAR_CYCLES = 32;

    // F7 after reset: inverse set, video enable bit low
    localparam logic [7:0] VIDMODE_RESET = 8'h80;

    typedef struct packed {
        logic [7:0] roller_ptr;
        logic [7:0] yscroll;
        logic       inverse;
        logic       disable_vid;    // High blanks the display
    } video_ctrl_t;

    typedef struct packed {
        logic disk_to_nmi;      // Floppy interrupt routed to NMI
        logic disk_to_int;      // Floppy interrupt routed to INT
        logic tc;               // Terminal count to the FDC
        logic motor;
        logic speaker_enable;
    } sys_ctrl_t;

    typedef struct packed {
        logic                 fdc_latch;
        logic [MISS_BITS-1:0] miss_count;
    } int_status_t;

endpackage

`default_nettype wire

/* design/io_map_pkg.sv */
// I/O map for the system control block: port numbers, command codes and bus payloads
`default_nettype none

package io_map_pkg;

    // Paging windows, one per 16 KB CPU bank
    localparam logic [7:0] PORT_PAGE0     = 8'hF0;
    localparam logic [7:0] PORT_PAGE1     = 8'hF1;
    localparam logic [7:0] PORT_PAGE2     = 8'hF2;
    localparam logic [7:0] PORT_PAGE3     = 8'hF3;
    localparam logic [7:0] PORT_TIMER_ACK = 8'hF4;  // Read returns status, starts timer clear
    localparam logic [7:0] PORT_ROLLER    = 8'hF5;  // Roller RAM pointer
    localparam logic [7:0] PORT_YSCROLL   = 8'hF6;
    localparam logic [7:0] PORT_VIDMODE   = 8'hF7;  // Inverse and disable bits
    localparam logic [7:0] PORT_STATUS    = 8'hF8;  // Status read, command write

    // Low nibble of a port F8 write
    localparam logic [3:0] CMD_DISK_NMI  = 4'd2;
    localparam logic [3:0] CMD_DISK_INT  = 4'd3;
    localparam logic [3:0] CMD_DISK_OFF  = 4'd4;   // Floppy disconnected from INT and NMI
    localparam logic [3:0] CMD_TC_SET    = 4'd5;
    localparam logic [3:0] CMD_TC_CLR    = 4'd6;
    localparam logic [3:0] CMD_MOTOR_ON  = 4'd9;
    localparam logic [3:0] CMD_MOTOR_OFF = 4'd10;
    localparam logic [3:0] CMD_SPK_ON    = 4'd11;
    localparam logic [3:0] CMD_SPK_OFF   = 4'd12;

    // Bus floats high on writes and on ports nobody decodes
    localparam logic [7:0] IDLE_READ_DATA = 8'hFF;

    typedef struct packed {
        logic       wr;     // 1 = OUT, 0 = IN
        logic [7:0] port;   // Low byte of the I/O address
        logic [7:0] data;   // Write data, ignored on reads
    } io_req_t;

    typedef struct packed {
        logic [7:0] data;
    } io_rsp_t;

endpackage

`default_nettype wire
